// File: flist.f
+incdir+rtl
rtl/pe_ctrl_pkg.sv
rtl/pe_data_pkg.sv
rtl/operand_loader.sv
rtl/bit_plane_driver.sv
rtl/column_accumulator.sv
rtl/result_sender.sv
rtl/pe_cell_ctrl.sv
bench/tb_pe_cell_ctrl.sv

// File: run.sh
#!/bin/sh
# build and run the pe_cell_ctrl testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f flist.f --top-module tb_pe_cell_ctrl -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_pe_cell_ctrl)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

echo "$out" | grep -q "^Everything OK$" || exit 1
exit 0

// File: bench/tb_pe_cell_ctrl.sv
`timescale 1ns/1ps
`include "pe_defs.svh"

module tb_pe_cell_ctrl
	import pe_ctrl_pkg::*;
	import pe_data_pkg::*;
();

	localparam int WAIT_LIMIT = 4000;

	logic       clk = 1'b0;
	logic       rst_n, cs_n, cvalid, wdata_valid, rdata_busy, pim_ready;
	work_mode_e work_mode;
	pe_id_t     pe_id;
	trunc_t     reg_data_trunc;
	bus_byte_t  wdata, rdata;
	logic       wdata_busy, pe_busy, rdata_valid, rdata_last, pulse_in, rst_pe_rram;
	row_vec_t   xin;
	col_vec_t   partial_result;

	bus_byte_t   ops [`PE_ROWS];
	bus_byte_t   got_data [`PE_GROUPS+1];
	logic        got_last [`PE_GROUPS+1];
	int          got_count, checks, errors, timeouts;
	int          rram_lows;
	logic [31:0] lfsr_q, model_q;
	row_vec_t    model_rows;
	logic [7:0]  model_wait;

	pe_cell_ctrl uut (.*);

	always #5 clk = ~clk;

	// array reset strobes, one per evaluation
	always @(negedge clk) begin
		if (rst_n && !rst_pe_rram)
			rram_lows++;
	end

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
	endfunction

	task automatic draw_bits(inout logic [31:0] st, input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			st = lfsr_next(st);
			v  = {v[6:0], st[0]};
		end
	endtask

	// row r holds operand byte r, weight bit set where (7r + c) mod 3 is 0
	function automatic col_vec_t array_counts(row_vec_t rows);
		col_vec_t pr;
		int       n;
		for (int c = 0; c < `PE_COLS; c++) begin
			n = 0;
			for (int r = 0; r < `PE_ROWS; r++)
				if (rows[`PE_ROWS-1-r] && (r * 7 + c) % 3 == 0)
					n++;
			pr[c*`PE_X_BITS +: `PE_X_BITS] = 6'(n);
		end
		return pr;
	endfunction

	function automatic int plane_count(int p, int c);
		int n;
		n = 0;
		for (int r = 0; r < `PE_ROWS; r++)
			if (ops[r][p] && (r * 7 + c) % 3 == 0)
				n++;
		return n;
	endfunction

	function automatic logic [21:0] expect_sum(work_mode_e m, int g);
		int s, pv;
		s = 0;
		if (m == MODE_READ) begin
			for (int k = 0; k < 8; k++)
				s += (plane_count(0, g * 8 + k) & 1) << k; // column lsb pattern
			return s[21:0];
		end
		for (int p = 0; p < 8; p++) begin
			pv = -(plane_count(p, g * 8 + 7) << 7);
			for (int k = 0; k < 7; k++)
				pv += plane_count(p, g * 8 + k) << k;
			s = (p == 7) ? s - (pv << 7) : s + (pv << p);
		end
		return s[21:0];
	endfunction

	function automatic bus_byte_t expect_byte(logic [21:0] s, int t);
		bus_byte_t b;
		if (t == 15)
			return s[7:0];
		b[7] = s[21];
		for (int i = 0; i < 7; i++)
			b[6-i] = s[20-t-i];
		return b;
	endfunction

	task automatic check_equal(string test, string what, logic [31:0] exp, logic [31:0] act);
		checks++;
		assert (act == exp) else begin
			errors++;
			$display("error %s %s: expected %0h, actual %0h", test, what, exp, act);
		end
	endtask

	task automatic report_timeout(string what);
		timeouts++;
		$display("timed out waiting for %s", what);
	endtask

	task automatic issue_command(work_mode_e m);
		cs_n      <= 1'b0;
		cvalid    <= 1'b1;
		work_mode <= m;
		@(posedge clk);
		cs_n   <= 1'b1;
		cvalid <= 1'b0;
	endtask

	task automatic make_operands();
		for (int i = 0; i < `PE_ROWS; i++)
			draw_bits(lfsr_q, 8, ops[i]);
	endtask

	task automatic send_operands(bit gaps);
		logic [7:0] gap;
		int         n;
		bit         taken;
		for (int i = 0; i < `PE_ROWS; i++) begin
			gap = '0;
			if (gaps)
				draw_bits(lfsr_q, 2, gap);
			if (gap != 0) begin
				wdata_valid <= 1'b0;
				repeat (gap) @(posedge clk);
			end
			wdata       <= ops[i];
			wdata_valid <= 1'b1;
			taken = 1'b0;
			n     = 0;
			while (!taken && n < WAIT_LIMIT) begin
				@(negedge clk);
				taken = !wdata_busy; // accepted at the coming edge
				@(posedge clk);
				n++;
			end
			if (!taken)
				report_timeout("an operand byte to be accepted");
		end
		wdata_valid <= 1'b0;
	endtask

	task automatic collect_results(bit bp);
		logic [7:0] busy;
		int         n;
		got_count = 0;
		n         = 0;
		while (got_count <= `PE_GROUPS && n < WAIT_LIMIT) begin
			busy = '0;
			if (bp)
				draw_bits(lfsr_q, 1, busy);
			rdata_busy <= busy[0];
			@(negedge clk);
			if (rdata_valid && !rdata_busy) begin
				got_data[got_count] = rdata;
				got_last[got_count] = rdata_last;
				got_count++;
			end
			@(posedge clk);
			n++;
		end
		rdata_busy <= 1'b0;
		if (got_count <= `PE_GROUPS)
			report_timeout("the result beats");
	endtask

	task automatic run_test(string name, work_mode_e m, int t, bit bp);
		bus_byte_t exp;
		int        n;
		reg_data_trunc <= 4'(t);
		issue_command(m);
		rram_lows = 0;
		@(negedge clk);
		check_equal(name, "pe_busy after command", 1, 32'(pe_busy));
		@(posedge clk);
		send_operands(bp);
		collect_results(bp);
		for (int i = 0; i < got_count; i++) begin
			exp = (i == 0) ? {1'b0, pe_id} : expect_byte(expect_sum(m, i - 1), t);
			check_equal(name, $sformatf("beat %0d", i), 32'(exp), 32'(got_data[i]));
			check_equal(name, $sformatf("last flag %0d", i), 32'(i == `PE_GROUPS),
				32'(got_last[i]));
		end
		n = 0;
		@(negedge clk);
		while (pe_busy && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (pe_busy)
			report_timeout("pe_busy to fall");
		check_equal(name, "rst_pe_rram low cycles", `PE_PLANES, rram_lows);
		@(posedge clk);
	endtask

	task automatic ignored_mode(string name, work_mode_e m);
		int pulses, busy_cycles, open_cycles;
		pulses      = 0;
		busy_cycles = 0;
		open_cycles = 0;
		issue_command(m);
		repeat (30) begin
			@(negedge clk);
			if (pulse_in)
				pulses++;
			if (pe_busy)
				busy_cycles++;
			if (!wdata_busy)
				open_cycles++;
		end
		@(posedge clk);
		check_equal(name, "pulse_in cycles", 0, pulses);
		check_equal(name, "pe_busy cycles", 0, busy_cycles);
		check_equal(name, "wdata_busy low cycles", 0, open_cycles);
	endtask

	task automatic check_reset();
		@(negedge clk);
		check_equal("reset", "wdata_busy", 1, 32'(wdata_busy));
		check_equal("reset", "pe_busy", 0, 32'(pe_busy));
		check_equal("reset", "pulse_in", 0, 32'(pulse_in));
		check_equal("reset", "rdata_valid", 0, 32'(rdata_valid));
		check_equal("reset", "rdata_last", 0, 32'(rdata_last));
		@(posedge clk);
	endtask

	// array model, answers each row pulse after a short random delay
	initial begin
		model_q        = 32'h45d1;
		pim_ready      <= 1'b0;
		partial_result <= '0;
		forever begin
			@(negedge clk);
			if (pulse_in) begin
				model_rows = xin;
				draw_bits(model_q, 2, model_wait);
				repeat (model_wait + 1) @(posedge clk);
				partial_result <= array_counts(model_rows); // held until next answer
				pim_ready      <= 1'b1;
				draw_bits(model_q, 2, model_wait);
				repeat (model_wait + 1) @(posedge clk);
				pim_ready <= 1'b0;
			end
		end
	end

	initial begin
		checks         = 0;
		errors         = 0;
		timeouts       = 0;
		rram_lows      = 0;
		lfsr_q         = 32'h45d1;
		rst_n          <= 1'b0;
		cs_n           <= 1'b1;
		cvalid         <= 1'b0;
		work_mode      <= MODE_NONE;
		pe_id          <= 7'h2b;
		reg_data_trunc <= 4'd15;
		wdata          <= '0;
		wdata_valid    <= 1'b0;
		rdata_busy     <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		check_equal("reset", "rst_pe_rram", 0, 32'(rst_pe_rram));
		@(posedge clk);
		rst_n <= 1'b1;

		check_reset();
		make_operands();
		run_test("compute_trunc15", MODE_COMPUTE, 15, 1'b0);
		run_test("compute_trunc0", MODE_COMPUTE, 0, 1'b0);
		run_test("compute_trunc5", MODE_COMPUTE, 5, 1'b0);
		run_test("backpressure", MODE_COMPUTE, 15, 1'b1); // same operands as trunc 15
		make_operands();
		run_test("read_mode", MODE_READ, 15, 1'b0);
		ignored_mode("mode_none", MODE_NONE);
		ignored_mode("mode_write", MODE_WRITE);

		$display("%0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: rtl/pe_cell_ctrl.sv
`timescale 1ns/1ps
`include "pe_defs.svh"

module pe_cell_ctrl
	import pe_ctrl_pkg::*;
	import pe_data_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	// host
	input  logic       cs_n,
	input  logic       cvalid,
	input  work_mode_e work_mode,
	input  pe_id_t     pe_id,
	input  trunc_t     reg_data_trunc,
	input  bus_byte_t  wdata,
	input  logic       wdata_valid,
	output logic       wdata_busy,
	output logic       pe_busy,
	// result stream
	output bus_byte_t  rdata,
	output logic       rdata_valid,
	output logic       rdata_last,
	input  logic       rdata_busy,
	// array
	output row_vec_t   xin,
	output logic       pulse_in,
	output logic       rst_pe_rram,
	input  logic       pim_ready,
	input  col_vec_t   partial_result
);

	bus_byte_t [`PE_ROWS-1:0] cache_rows;
	work_mode_e               mode;
	plane_idx_t               plane;
	acc_arr_t                 sums;
	logic                     load_done, pim_rise, sums_valid, send_done;

	operand_loader u_loader (
		.clk, .rst_n, .cs_n, .cvalid, .work_mode, .wdata, .wdata_valid, .send_done,
		.wdata_busy, .pe_busy, .load_done, .mode, .cache_rows
	);

	bit_plane_driver u_driver (
		.clk, .rst_n, .load_done, .cache_rows, .pim_ready,
		.xin, .pulse_in, .rst_pe_rram, .plane, .pim_rise, .pim_fall()
	);

	column_accumulator u_accum (
		.clk, .rst_n, .load_done, .mode, .plane, .pim_rise, .partial_result,
		.sums, .sums_valid
	);

	result_sender u_sender (
		.clk, .rst_n, .sums, .sums_valid, .pe_id, .trunc(reg_data_trunc), .rdata_busy,
		.rdata, .rdata_valid, .rdata_last, .send_done
	);

endmodule

// File: rtl/result_sender.sv
`timescale 1ns/1ps
`include "pe_defs.svh"

module result_sender
	import pe_data_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  acc_arr_t  sums,
	input  logic      sums_valid,
	input  pe_id_t    pe_id,
	input  trunc_t    trunc,
	input  logic      rdata_busy,
	output bus_byte_t rdata,
	output logic      rdata_valid,
	output logic      rdata_last,
	output logic      send_done
);

	localparam send_idx_t LAST_BEAT = 6'(`PE_GROUPS);

	logic       sv_d;
	logic       xfer;
	send_idx_t  beat;
	logic [4:0] grp;

	function automatic bus_byte_t trunc_sum(acc_t s, trunc_t t);
		if (t == 4'd15)
			return s[7:0];
		return {s[`PE_ACC_BITS-1], s[(`PE_ACC_BITS - 2 - t) -: 7]};
	endfunction

	assign xfer = rdata_valid & ~rdata_busy;
	assign grp  = beat[4:0] - 5'd1; // beat n carries sum n-1

	always_comb begin
		if (!rdata_valid)
			rdata = '0;
		else if (beat == '0)
			rdata = {1'b0, pe_id};
		else
			rdata = trunc_sum(sums[grp], trunc);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sv_d        <= 1'b0;
			beat        <= '0;
			rdata_valid <= 1'b0;
			rdata_last  <= 1'b0;
			send_done   <= 1'b0;
		end else begin
			sv_d      <= sums_valid;
			send_done <= 1'b0;
			if (sums_valid && !sv_d) begin
				rdata_valid <= 1'b1;
				beat        <= '0;
			end else if (xfer) begin
				if (beat == LAST_BEAT) begin
					rdata_valid <= 1'b0;
					rdata_last  <= 1'b0;
					send_done   <= 1'b1;
					beat        <= '0;
				end else begin
					beat       <= beat + 6'd1;
					rdata_last <= (beat == LAST_BEAT - 6'd1);
				end
			end
		end
	end

	a_last_beat: assert property (@(posedge clk) disable iff (!rst_n)
		rdata_last |-> rdata_valid && beat == LAST_BEAT);

endmodule

// File: rtl/column_accumulator.sv
`timescale 1ns/1ps
`include "pe_defs.svh"

module column_accumulator
	import pe_ctrl_pkg::*;
	import pe_data_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       load_done,
	input  work_mode_e mode,
	input  plane_idx_t plane,
	input  logic       pim_rise,
	input  col_vec_t   partial_result,
	output acc_arr_t   sums,
	output logic       sums_valid
);

	localparam plane_idx_t LAST_PLANE = 3'(`PE_PLANES - 1);

	acc_arr_t                                 grp_w;
	logic [`PE_GROUPS-1:0][`PE_GROUP-1:0]     grp_lsb;

	// column k weighs 2^k, column 7 is the sign column
	always_comb begin
		acc_t w;
		int   base;
		for (int g = 0; g < `PE_GROUPS; g++) begin
			base = g * `PE_GROUP;
			w = '0;
			for (int k = 0; k < `PE_GROUP - 1; k++)
				w = w + (acc_t'(partial_result[(base + k) * `PE_X_BITS +: `PE_X_BITS]) << k);
			w = w - (acc_t'(partial_result[(base + 7) * `PE_X_BITS +: `PE_X_BITS]) << 7);
			grp_w[g] = w;
			for (int k = 0; k < `PE_GROUP; k++)
				grp_lsb[g][k] = partial_result[(base + k) * `PE_X_BITS];
		end
	end

	always_ff @(posedge clk) begin
		if (!load_done) begin
			sums <= '0;
		end else if (pim_rise) begin
			for (int g = 0; g < `PE_GROUPS; g++) begin
				if (mode == MODE_COMPUTE) begin
					if (plane == LAST_PLANE)
						sums[g] <= sums[g] - (grp_w[g] << plane); // msb plane negative
					else
						sums[g] <= sums[g] + (grp_w[g] << plane);
				end else if (mode == MODE_READ && plane == '0) begin
					sums[g] <= acc_t'(grp_lsb[g]);
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			sums_valid <= 1'b0;
		else if (!load_done)
			sums_valid <= 1'b0;
		else if (pim_rise && plane == LAST_PLANE)
			sums_valid <= 1'b1;
	end

	// array must not answer outside a run
	a_rise_in_run: assert property (@(posedge clk) disable iff (!rst_n)
		pim_rise |-> load_done);

endmodule

// File: rtl/bit_plane_driver.sv
`timescale 1ns/1ps
`include "pe_defs.svh"

module bit_plane_driver
	import pe_data_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     load_done,
	input  bus_byte_t [`PE_ROWS-1:0] cache_rows,
	input  logic                     pim_ready,
	output row_vec_t                 xin,
	output logic                     pulse_in,
	output logic                     rst_pe_rram,
	output plane_idx_t               plane,
	output logic                     pim_rise,
	output logic                     pim_fall
);

	logic       pim_d1, pim_d2;
	logic       load_d;
	logic       start;
	logic       fire;
	plane_idx_t next_plane;
	row_vec_t   row_bits;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pim_d1 <= 1'b0;
			pim_d2 <= 1'b0;
			load_d <= 1'b0;
		end else begin
			pim_d1 <= pim_ready; // async from array
			pim_d2 <= pim_d1;
			load_d <= load_done;
		end
	end

	assign pim_rise   = pim_d1 & ~pim_d2;
	assign pim_fall   = pim_d2 & ~pim_d1;
	assign start      = load_done & ~load_d;
	assign fire       = start | (load_done & pim_fall & (plane != 3'(`PE_PLANES - 1)));
	assign next_plane = start ? '0 : plane + 3'd1;

	// byte 0 lands in the msb
	always_comb begin
		for (int r = 0; r < `PE_ROWS; r++)
			row_bits[`PE_ROWS-1-r] = cache_rows[r][next_plane];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			plane    <= '0;
			pulse_in <= 1'b0;
			xin      <= '0;
		end else if (!load_done) begin
			plane    <= '0;
			pulse_in <= 1'b0;
			xin      <= '0;
		end else begin
			pulse_in <= fire;
			if (fire) begin
				plane <= next_plane;
				xin   <= row_bits;
			end
		end
	end

	// one low cycle after each evaluation, low in reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rst_pe_rram <= 1'b0;
		else
			rst_pe_rram <= ~pim_rise;
	end

	a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		pulse_in |=> !pulse_in);

endmodule

// File: rtl/operand_loader.sv
`timescale 1ns/1ps
`include "pe_defs.svh"

module operand_loader
	import pe_ctrl_pkg::*;
	import pe_data_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          cs_n,
	input  logic                          cvalid,
	input  work_mode_e                    work_mode,
	input  bus_byte_t                     wdata,
	input  logic                          wdata_valid,
	input  logic                          send_done,
	output logic                          wdata_busy,
	output logic                          pe_busy,
	output logic                          load_done,
	output work_mode_e                    mode,
	output bus_byte_t [`PE_ROWS-1:0]      cache_rows
);

	pe_state_e  state;
	logic [5:0] byte_cnt;
	logic       cmd_ok;
	logic       take;

	always_comb begin
		case (work_mode)
			MODE_COMPUTE, MODE_READ: cmd_ok = !cs_n && cvalid;
			MODE_NONE, MODE_WRITE:   cmd_ok = 1'b0;
			default:                 cmd_ok = 1'b0;
		endcase
	end

	assign wdata_busy = (state != ST_LOAD);
	assign pe_busy    = (state != ST_IDLE);
	assign load_done  = (state == ST_RUN);
	assign take       = wdata_valid && !wdata_busy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			mode     <= MODE_NONE;
			byte_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					byte_cnt <= '0;
					if (cmd_ok) begin
						mode  <= work_mode;
						state <= ST_LOAD;
					end
				end
				ST_LOAD: if (take) begin
					byte_cnt <= byte_cnt + 6'd1;
					if (byte_cnt == 6'(`PE_ROWS - 1))
						state <= ST_RUN; // last operand byte
				end
				ST_RUN: if (send_done) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// byte 0 at index 0
	always_ff @(posedge clk) begin
		if (state == ST_IDLE)
			cache_rows <= '0;
		else if (take)
			cache_rows[byte_cnt] <= wdata;
	end

	// result stream only ends during a run
	a_done_in_run: assert property (@(posedge clk) disable iff (!rst_n)
		send_done |-> state == ST_RUN);

endmodule

// File: rtl/pe_data_pkg.sv
package pe_data_pkg;

	`include "pe_defs.svh"

	typedef logic [`PE_ROWS-1:0]     row_vec_t;  // one bit plane
	typedef logic [`PE_BUS_BITS-1:0] bus_byte_t;
	typedef logic [2:0]              plane_idx_t;

	// count of column c at [c*X_BITS +: X_BITS]
	typedef logic [`PE_COLS*`PE_X_BITS-1:0] col_vec_t;

	typedef logic [`PE_ACC_BITS-1:0] acc_t;
	typedef acc_t [`PE_GROUPS-1:0]   acc_arr_t;

	typedef logic [3:0] trunc_t;
	typedef logic [6:0] pe_id_t;
	typedef logic [5:0] send_idx_t; // 0 is the id beat

endpackage

// File: rtl/pe_ctrl_pkg.sv
package pe_ctrl_pkg;

	typedef enum logic [1:0] {
		MODE_NONE    = 2'b00,
		MODE_COMPUTE = 2'b01,
		MODE_READ    = 2'b10,
		MODE_WRITE   = 2'b11 // not supported, ignored
	} work_mode_e;

	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_LOAD = 2'd1, // collecting operand bytes
		ST_RUN  = 2'd2
	} pe_state_e;

endpackage

// File: rtl/pe_defs.svh
`ifndef PE_DEFS_SVH
`define PE_DEFS_SVH

// array geometry
`define PE_ROWS     36
`define PE_COLS     256
`define PE_GROUP    8   // columns per weight
`define PE_GROUPS   32
`define PE_X_BITS   6   // column count width
`define PE_PLANES   8

// datapath
`define PE_ACC_BITS 22
`define PE_BUS_BITS 8

`endif
